//--- list.f
+incdir+testbench
source/isa_pkg.sv
source/pipe_pkg.sv
source/wb_if.sv
source/regfile.sv
source/fetch_unit.sv
source/decode_unit.sv
source/hazard_unit.sv
source/execute_unit.sv
source/memory_unit.sv
source/lc4_core.sv
testbench/tb_lc4_core.sv

//--- source/decode_unit.sv
/*
 * D stage: decodes the F/D instruction, reads the register file and
 * fills the D/X latch, or a bubble on stall, redirect or an empty slot.
 */
module decode_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst_n,
    input  fd_t      i_fd,
    input  logic     i_stall,
    input  logic     i_redirect,
    input  word_t    i_rs_val,
    input  word_t    i_rt_val,
    output reg_sel_t o_rs_sel,
    output reg_sel_t o_rt_sel,
    output ctrl_t    o_d_ctrl,
    output dx_t      o_dx
);

    word_t insn;
    ctrl_t dec;
    dx_t   dx_next;

    assign insn = i_fd.insn;

    always_comb begin
        dec = '0;
        case (opcode_t'(insn[15:12]))
            OP_BR: begin
                // empty mask is a NOP
                dec.is_branch = |insn[11:9];
                dec.br_mask   = insn[11:9];
                dec.imm       = {{7{insn[8]}}, insn[8:0]};
            end
            OP_ARITH: begin
                dec.rd = insn[11:9];
                dec.rs = insn[8:6];
                dec.rt = insn[2:0];
                if (insn[5]) begin
                    dec.alu_op = ALU_ADDI;
                    dec.imm    = {{11{insn[4]}}, insn[4:0]};
                    dec.rd_we  = 1'b1;
                end else if (insn[5:3] == 3'b000 || insn[5:3] == 3'b010) begin
                    // sub-op bit 4 separates SUB from ADD
                    dec.alu_op = insn[4] ? ALU_SUB : ALU_ADD;
                    dec.rt_re  = 1'b1;
                    dec.rd_we  = 1'b1;
                end
                // MUL and DIV fall out as no-ops
                dec.rs_re  = dec.rd_we;
                dec.nzp_we = dec.rd_we;
            end
            OP_LOGIC: begin
                dec.rd     = insn[11:9];
                dec.rs     = insn[8:6];
                dec.rt     = insn[2:0];
                dec.alu_op = ALU_AND;
                dec.rd_we  = (insn[5:3] == 3'b000);
                dec.rs_re  = dec.rd_we;
                dec.rt_re  = dec.rd_we;
                dec.nzp_we = dec.rd_we;
            end
            OP_LDR: begin
                dec.rd      = insn[11:9];
                dec.rs      = insn[8:6];
                dec.rs_re   = 1'b1;
                dec.is_load = 1'b1;
                dec.rd_we   = 1'b1;
                dec.nzp_we  = 1'b1;
                dec.alu_op  = ALU_ADDR_CALC;
                dec.imm     = {{10{insn[5]}}, insn[5:0]};
            end
            OP_STR: begin
                // store data register sits in the rd field
                dec.rt       = insn[11:9];
                dec.rs       = insn[8:6];
                dec.rs_re    = 1'b1;
                dec.rt_re    = 1'b1;
                dec.is_store = 1'b1;
                dec.alu_op   = ALU_ADDR_CALC;
                dec.imm      = {{10{insn[5]}}, insn[5:0]};
            end
            OP_CONST: begin
                dec.rd     = insn[11:9];
                dec.rd_we  = 1'b1;
                dec.nzp_we = 1'b1;
                dec.alu_op = ALU_PASS_IMM;
                dec.imm    = {{7{insn[8]}}, insn[8:0]};
            end
            default: begin
                dec = '0;
            end
        endcase
    end

    assign o_rs_sel = dec.rs;
    assign o_rt_sel = dec.rt;
    // empty F/D slot has no hazards
    assign o_d_ctrl = i_fd.valid ? dec : ctrl_t'('0);

    always_comb begin
        dx_next = '0;
        if (i_redirect || !i_fd.valid) begin
            dx_next.stall = STALL_FLUSH;
        end else if (i_stall) begin
            dx_next.stall = STALL_LOAD;
        end else begin
            dx_next.valid  = 1'b1;
            dx_next.stall  = STALL_NONE;
            dx_next.pc     = i_fd.pc;
            dx_next.insn   = insn;
            dx_next.ctrl   = dec;
            dx_next.rs_val = i_rs_val;
            dx_next.rt_val = i_rt_val;
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dx       <= '0;
            o_dx.stall <= STALL_FLUSH;
        end else begin
            o_dx <= dx_next;
        end
    end

endmodule

//--- source/execute_unit.sv
/*
 * X stage: operand bypass, ALU, NZP register and branch resolution.
 * Redirect and target are combinational; results go to the X/M latch.
 */
module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic  gwe,
    input  logic  i_rst_n,
    input  dx_t   i_dx,
    wb_if.dst     wb,
    output xm_t   o_xm,
    output logic  o_redirect,
    output word_t o_target
);

    word_t rs_op;
    word_t rt_op;
    word_t alu_res;
    nzp_t  nzp_q;
    nzp_t  nzp_cur;

    function automatic nzp_t nzp_of(input word_t v);
        if (v[15]) begin
            return 3'b100;
        end
        if (v == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // M first, then W, then the latched register value
    // a load in M holds an address, never forwarded
    function automatic word_t bypass(input reg_sel_t sel, input word_t latched);
        if (o_xm.ctrl.rd_we && !o_xm.ctrl.is_load && o_xm.ctrl.rd == sel) begin
            return o_xm.result;
        end
        if (wb.we && wb.sel == sel) begin
            return wb.data;
        end
        return latched;
    endfunction

    always_comb begin
        rs_op = bypass(i_dx.ctrl.rs, i_dx.rs_val);
        rt_op = bypass(i_dx.ctrl.rt, i_dx.rt_val);
    end

    always_comb begin
        case (i_dx.ctrl.alu_op)
            ALU_ADD:       alu_res = rs_op + rt_op;
            ALU_SUB:       alu_res = rs_op - rt_op;
            ALU_AND:       alu_res = rs_op & rt_op;
            ALU_PASS_IMM:  alu_res = i_dx.ctrl.imm;
            ALU_ADDI,
            ALU_ADDR_CALC: alu_res = rs_op + i_dx.ctrl.imm;
            default:       alu_res = '0;
        endcase
    end

    // architectural nzp, written at W
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q <= '0;
        end else if (wb.nzp_we) begin
            nzp_q <= nzp_of(wb.data);
        end
    end

    // youngest older writer; load in M is excluded by the hazard stall
    always_comb begin
        if (o_xm.ctrl.nzp_we) begin
            nzp_cur = nzp_of(o_xm.result);
        end else if (wb.nzp_we) begin
            nzp_cur = nzp_of(wb.data);
        end else begin
            nzp_cur = nzp_q;
        end
    end

    // bubbles carry zero ctrl, so no redirect
    assign o_redirect = i_dx.ctrl.is_branch && |(i_dx.ctrl.br_mask & nzp_cur);
    assign o_target   = i_dx.pc + 16'd1 + i_dx.ctrl.imm;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_xm       <= '0;
            o_xm.stall <= STALL_FLUSH;
        end else begin
            o_xm.valid      <= i_dx.valid;
            o_xm.stall      <= i_dx.stall;
            o_xm.pc         <= i_dx.pc;
            o_xm.insn       <= i_dx.insn;
            o_xm.ctrl       <= i_dx.ctrl;
            o_xm.result     <= alu_res;
            o_xm.store_data <= rt_op;
        end
    end

endmodule

//--- source/fetch_unit.sv
/*
 * F stage: program counter, next-PC choice and the F/D latch.
 */
module fetch_unit import isa_pkg::*, pipe_pkg::*; #(
    parameter word_t RESET_PC = 16'h0000
) (
    input  logic  gwe,
    input  logic  i_rst_n,
    input  word_t i_insn,
    input  logic  i_stall,
    input  logic  i_redirect,
    input  word_t i_target,
    output word_t o_pc,
    output fd_t   o_fd
);

    word_t pc_next;

    // taken branch beats a load stall
    always_comb begin
        if (i_redirect) begin
            pc_next = i_target;
        end else if (i_stall) begin
            pc_next = o_pc;
        end else begin
            pc_next = o_pc + 16'd1;
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

    // F/D latch, emptied by reset or redirect, frozen by stall
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_fd <= '{valid: 1'b0, pc: '0, insn: NOP_INSN};
        end else if (i_redirect) begin
            o_fd <= '{valid: 1'b0, pc: '0, insn: NOP_INSN};
        end else if (!i_stall) begin
            o_fd <= '{valid: 1'b1, pc: o_pc, insn: i_insn};
        end
    end

endmodule

//--- source/hazard_unit.sv
/*
 * Load-to-use and load-to-branch detection between D and X.
 * Stalls the F and D stages for one cycle.
 */
module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  ctrl_t i_d_ctrl,
    input  dx_t   i_dx,
    output logic  o_stall
);

    logic x_load;
    logic rs_dep;
    logic rt_dep;

    assign x_load = i_dx.valid && i_dx.ctrl.is_load;

    assign rs_dep = i_d_ctrl.rs_re && i_d_ctrl.rs == i_dx.ctrl.rd;
    // store data is caught later by the W to M bypass
    assign rt_dep = i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt == i_dx.ctrl.rd;

    // a branch needs the load's nzp, which is known only in W
    assign o_stall = x_load && (rs_dep || rt_dep || i_d_ctrl.is_branch);

endmodule

//--- source/isa_pkg.sv
/*
 * LC4 instruction set types shared by all pipeline stages.
 * Modules take it by wildcard import in their header.
 */
package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0] reg_sel_t;
    // one-hot: bit 2 = n, bit 1 = z, bit 0 = p
    typedef logic [2:0] nzp_t;

    // insn[15:12], only the supported subset
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ADDI,
        ALU_PASS_IMM,
        ALU_ADDR_CALC
    } alu_op_t;

    // decoded control, all zero for a bubble
    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        alu_op_t  alu_op;
        word_t    imm;
        nzp_t     br_mask;
    } ctrl_t;

    // BR with empty mask
    localparam word_t NOP_INSN = 16'h0000;

endpackage

//--- source/lc4_core.sv
/*
 * Five-stage single-issue LC4 core with combinational instruction and
 * data memories outside; the W stage is exposed as a trace.
 */
module lc4_core import isa_pkg::*, pipe_pkg::*; #(
    parameter word_t RESET_PC = pipe_pkg::RESET_PC
) (
    input  logic     gwe,
    input  logic     i_rst_n,
    input  word_t    i_imem_insn,
    input  word_t    i_dmem_rdata,
    output word_t    o_imem_addr,
    output word_t    o_dmem_addr,
    output logic     o_dmem_we,
    output word_t    o_dmem_wdata,
    output logic     o_wb_valid,
    output word_t    o_wb_pc,
    output word_t    o_wb_insn,
    output logic     o_wb_we,
    output reg_sel_t o_wb_sel,
    output word_t    o_wb_data,
    output stall_t   o_wb_stall
);

    fd_t      fd;
    dx_t      dx;
    xm_t      xm;
    ctrl_t    d_ctrl;
    logic     stall;
    logic     redirect;
    word_t    target;
    reg_sel_t rs_sel;
    reg_sel_t rt_sel;
    word_t    rs_val;
    word_t    rt_val;

    // W stage result
    wb_if wb ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_insn     (i_imem_insn),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .o_pc       (o_imem_addr),
        .o_fd       (fd)
    );

    decode_unit u_decode (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_fd       (fd),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_rs_val   (rs_val),
        .i_rt_val   (rt_val),
        .o_rs_sel   (rs_sel),
        .o_rt_sel   (rt_sel),
        .o_d_ctrl   (d_ctrl),
        .o_dx       (dx)
    );

    regfile u_regfile (
        .gwe      (gwe),
        .i_rst_n  (i_rst_n),
        .i_rs_sel (rs_sel),
        .i_rt_sel (rt_sel),
        .wb       (wb.dst),
        .o_rs_val (rs_val),
        .o_rt_val (rt_val)
    );

    hazard_unit u_hazard (
        .i_d_ctrl (d_ctrl),
        .i_dx     (dx),
        .o_stall  (stall)
    );

    execute_unit u_execute (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_dx       (dx),
        .wb         (wb.dst),
        .o_xm       (xm),
        .o_redirect (redirect),
        .o_target   (target)
    );

    memory_unit u_memory (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_xm         (xm),
        .i_dmem_rdata (i_dmem_rdata),
        .wb           (wb.src),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .o_wb_valid   (o_wb_valid),
        .o_wb_pc      (o_wb_pc),
        .o_wb_insn    (o_wb_insn),
        .o_wb_we      (o_wb_we),
        .o_wb_sel     (o_wb_sel),
        .o_wb_data    (o_wb_data),
        .o_wb_stall   (o_wb_stall)
    );

endmodule

//--- source/memory_unit.sv
/*
 * M and W stages: data memory access, store data bypass from W,
 * the M/W latch and the writeback and trace outputs.
 */
module memory_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst_n,
    input  xm_t      i_xm,
    input  word_t    i_dmem_rdata,
    wb_if.src        wb,
    output word_t    o_dmem_addr,
    output logic     o_dmem_we,
    output word_t    o_dmem_wdata,
    output logic     o_wb_valid,
    output word_t    o_wb_pc,
    output word_t    o_wb_insn,
    output logic     o_wb_we,
    output reg_sel_t o_wb_sel,
    output word_t    o_wb_data,
    output stall_t   o_wb_stall
);

    xm_t   mw;
    word_t store_data;

    // W writes the register this store reads
    assign store_data = (mw.ctrl.rd_we && mw.ctrl.rd == i_xm.ctrl.rt) ? mw.result
                                                                        : i_xm.store_data;

    assign o_dmem_addr  = (i_xm.ctrl.is_load || i_xm.ctrl.is_store) ? i_xm.result : '0;
    assign o_dmem_we    = i_xm.ctrl.is_store;
    assign o_dmem_wdata = store_data;

    // result field holds the writeback value from here on
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mw       <= '0;
            mw.stall <= STALL_FLUSH;
        end else begin
            mw        <= i_xm;
            mw.result <= i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.result;
        end
    end

    assign wb.we     = mw.ctrl.rd_we;
    assign wb.sel    = mw.ctrl.rd;
    assign wb.data   = mw.result;
    assign wb.nzp_we = mw.ctrl.nzp_we;

    // trace of the retiring instruction or bubble
    assign o_wb_valid = mw.valid;
    assign o_wb_pc    = mw.pc;
    assign o_wb_insn  = mw.insn;
    assign o_wb_we    = mw.ctrl.rd_we;
    assign o_wb_sel   = mw.ctrl.rd;
    assign o_wb_data  = mw.result;
    assign o_wb_stall = mw.stall;

endmodule

//--- source/pipe_pkg.sv
/*
 * Pipeline latch payloads and stall codes passed between stages.
 */
package pipe_pkg;

    import isa_pkg::*;

    // trace stall codes, 1 is unused in a single pipe
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } fd_t;

    typedef struct packed {
        logic   valid;
        stall_t stall;
        word_t  pc;
        word_t  insn;
        ctrl_t  ctrl;
        word_t  rs_val;
        word_t  rt_val;
    } dx_t;

    typedef struct packed {
        logic   valid;
        stall_t stall;
        word_t  pc;
        word_t  insn;
        ctrl_t  ctrl;
        word_t  result;
        word_t  store_data;
    } xm_t;

    localparam word_t RESET_PC = 16'h8200;

endpackage

//--- source/regfile.sv
/*
 * Eight 16-bit registers, two read ports and one write port.
 * A read of the register being written returns the new value.
 */
module regfile import isa_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst_n,
    input  reg_sel_t i_rs_sel,
    input  reg_sel_t i_rt_sel,
    wb_if.dst        wb,
    output word_t    o_rs_val,
    output word_t    o_rt_val
);

    word_t regs [8];

    // W writes in the same cycle that D reads
    function automatic word_t read_port(input reg_sel_t sel);
        if (wb.we && wb.sel == sel) begin
            return wb.data;
        end
        return regs[sel];
    endfunction

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};
        end else if (wb.we) begin
            regs[wb.sel] <= wb.data;
        end
    end

    always_comb begin
        o_rs_val = read_port(i_rs_sel);
        o_rt_val = read_port(i_rt_sel);
    end

endmodule

//--- source/wb_if.sv
/*
 * Writeback port of the W stage, read by the register file and the X stage.
 */
interface wb_if import isa_pkg::*; ();

    logic     we;
    reg_sel_t sel;
    word_t    data;
    // nzp bits are derived from data by the reader
    logic     nzp_we;

    modport src (output we, output sel, output data, output nzp_we);
    modport dst (input we, input sel, input data, input nzp_we);

endinterface

//--- testbench/tb_program.svh
/*
 * Program, data memory presets and expected retirement rows for the core
 * testbench; included inside the testbench module after START_PC.
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 25;

// instruction words at START_PC + index
localparam word_t PROGRAM [PROG_LEN] = '{
    16'h9205,  // 0  CONST r1, 5
    16'h95FD,  // 1  CONST r2, -3
    16'h1642,  // 2  ADD   r3, r1, r2
    16'h18D1,  // 3  SUB   r4, r3, r1
    16'h5B03,  // 4  AND   r5, r4, r3
    16'h1D79,  // 5  ADD   r6, r5, #-7
    16'h1DAF,  // 6  ADD   r6, r6, #15 wraps past 2^16
    16'h9E40,  // 7  CONST r7, 64
    16'h63C2,  // 8  LDR   r1, r7, #2
    16'h1446,  // 9  ADD   r2, r1, r6 load use
    16'h75C5,  // 10 STR   r2, r7, #5
    16'h67C5,  // 11 LDR   r3, r7, #5
    16'h0202,  // 12 BRp   +2 right after the load
    16'h9801,  // 13 CONST r4, 1 squashed
    16'h9802,  // 14 CONST r4, 2 squashed
    16'h9BFF,  // 15 CONST r5, -1
    16'h0603,  // 16 BRzp  +3 mask misses
    16'h9C00,  // 17 CONST r6, 0
    16'h0402,  // 18 BRz   +2 taken
    16'h1DA1,  // 19 ADD   r6, r6, #1 squashed
    16'h1DA2,  // 20 ADD   r6, r6, #2 squashed
    16'h12C2,  // 21 ADD   r1, r3, r2
    16'h69C2,  // 22 LDR   r4, r7, #2
    16'h79C6,  // 23 STR   r4, r7, #6 data only from W
    16'h6BC6   // 24 LDR   r5, r7, #6
};

// words placed over the fill pattern, 0x45 is overwritten by the store
localparam int N_PRESET = 2;
localparam logic [7:0] PRESET_ADDR [N_PRESET] = '{8'h42, 8'h45};
localparam word_t PRESET_DATA [N_PRESET] = '{16'h1234, 16'hDEAD};

// one entry per retiring instruction, in program order
string    exp_name[$];
word_t    exp_pc[$];
word_t    exp_insn[$];
logic     exp_we[$];
reg_sel_t exp_sel[$];
word_t    exp_data[$];
int       exp_bubbles[$];
stall_t   exp_code[$];

// bubbles and code describe the gap in front of the row
task automatic add_exp(input string name, input int off, input word_t insn, input logic we,
                       input reg_sel_t sel, input word_t data, input int bubbles,
                       input stall_t code);
    exp_name.push_back(name);
    exp_pc.push_back(START_PC + word_t'(off));
    exp_insn.push_back(insn);
    exp_we.push_back(we);
    exp_sel.push_back(sel);
    exp_data.push_back(data);
    exp_bubbles.push_back(bubbles);
    exp_code.push_back(code);
endtask

task automatic fill_expected();
    //       name         off  insn      we    sel   data      gap code
    add_exp("const r1",     0, 16'h9205, 1'b1, 3'd1, 16'h0005, 4, STALL_FLUSH);
    add_exp("const r2",     1, 16'h95FD, 1'b1, 3'd2, 16'hFFFD, 0, STALL_NONE);
    add_exp("add r3",       2, 16'h1642, 1'b1, 3'd3, 16'h0002, 0, STALL_NONE);
    add_exp("sub r4",       3, 16'h18D1, 1'b1, 3'd4, 16'hFFFD, 0, STALL_NONE);
    add_exp("and r5",       4, 16'h5B03, 1'b1, 3'd5, 16'h0000, 0, STALL_NONE);
    add_exp("addi r6",      5, 16'h1D79, 1'b1, 3'd6, 16'hFFF9, 0, STALL_NONE);
    add_exp("addi wrap",    6, 16'h1DAF, 1'b1, 3'd6, 16'h0008, 0, STALL_NONE);
    add_exp("const r7",     7, 16'h9E40, 1'b1, 3'd7, 16'h0040, 0, STALL_NONE);
    add_exp("ldr r1",       8, 16'h63C2, 1'b1, 3'd1, 16'h1234, 0, STALL_NONE);
    add_exp("load use add", 9, 16'h1446, 1'b1, 3'd2, 16'h123C, 1, STALL_LOAD);
    add_exp("str r2",      10, 16'h75C5, 1'b0, 3'd0, 16'h0000, 0, STALL_NONE);
    add_exp("ldr stored",  11, 16'h67C5, 1'b1, 3'd3, 16'h123C, 0, STALL_NONE);
    add_exp("br on load",  12, 16'h0202, 1'b0, 3'd0, 16'h0000, 1, STALL_LOAD);
    add_exp("const r5",    15, 16'h9BFF, 1'b1, 3'd5, 16'hFFFF, 2, STALL_FLUSH);
    add_exp("br miss",     16, 16'h0603, 1'b0, 3'd0, 16'h0000, 0, STALL_NONE);
    add_exp("const r6",    17, 16'h9C00, 1'b1, 3'd6, 16'h0000, 0, STALL_NONE);
    add_exp("br taken",    18, 16'h0402, 1'b0, 3'd0, 16'h0000, 0, STALL_NONE);
    add_exp("add target",  21, 16'h12C2, 1'b1, 3'd1, 16'h2478, 2, STALL_FLUSH);
    add_exp("ldr r4",      22, 16'h69C2, 1'b1, 3'd4, 16'h1234, 0, STALL_NONE);
    add_exp("str r4",      23, 16'h79C6, 1'b0, 3'd0, 16'h0000, 0, STALL_NONE);
    add_exp("ldr wm store", 24, 16'h6BC6, 1'b1, 3'd5, 16'h1234, 0, STALL_NONE);
endtask

`endif

//--- testbench/tb_lc4_core.sv
/*
 * Testbench for the pipelined LC4 core: models both memories, runs the
 * program table and compares every trace cycle with the expected rows.
 */
module tb_lc4_core import isa_pkg::*, pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // differs from the package default so the parameter path is exercised
    localparam word_t START_PC = 16'h3100;

    `include "tb_program.svh"

    logic     gwe;
    logic     i_rst_n;
    word_t    i_imem_insn;
    word_t    i_dmem_rdata;
    word_t    o_imem_addr;
    word_t    o_dmem_addr;
    logic     o_dmem_we;
    word_t    o_dmem_wdata;
    logic     o_wb_valid;
    word_t    o_wb_pc;
    word_t    o_wb_insn;
    logic     o_wb_we;
    reg_sel_t o_wb_sel;
    word_t    o_wb_data;
    stall_t   o_wb_stall;

    // 256-word data memory, address taken from the low byte
    word_t      dmem [256];
    logic       wr_pend;
    logic [7:0] wr_addr;
    word_t      wr_data;

    lc4_core #(
        .RESET_PC (START_PC)
    ) uut (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_imem_insn  (i_imem_insn),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .o_wb_valid   (o_wb_valid),
        .o_wb_pc      (o_wb_pc),
        .o_wb_insn    (o_wb_insn),
        .o_wb_we      (o_wb_we),
        .o_wb_sel     (o_wb_sel),
        .o_wb_data    (o_wb_data),
        .o_wb_stall   (o_wb_stall)
    );

    // 20 ns period
    always #10 gwe = ~gwe;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_sel(input string name, input reg_sel_t exp, input reg_sel_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected r%0d actual r%0d", name, exp, act));
        end
    endtask

    task automatic check_stall(input string name, input stall_t exp, input stall_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // outside the program the core sees NOPs
    function automatic word_t fetch_insn(input word_t addr);
        word_t off;
        off = addr - START_PC;
        if (off < PROG_LEN) begin
            return PROGRAM[off];
        end
        return NOP_INSN;
    endfunction

    // store seen in M at the falling edge lands at the next rising edge
    // then both read ports are driven 1 ns after that edge
    always begin
        @(negedge gwe);
        wr_pend = o_dmem_we;
        wr_addr = o_dmem_addr[7:0];
        wr_data = o_dmem_wdata;
        @(posedge gwe);
        #1;
        if (wr_pend === 1'b1) begin
            dmem[wr_addr] = wr_data;
        end
        i_imem_insn  = fetch_insn(o_imem_addr);
        i_dmem_rdata = dmem[o_dmem_addr[7:0]];
    end

    initial begin
        int row;
        int bubbles;
        int cycles;
        int limit;
        gwe          = 1'b0;
        i_rst_n      = 1'b0;
        i_imem_insn  = NOP_INSN;
        i_dmem_rdata = '0;
        wr_pend      = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        // fill uses every address bit, presets go on top
        for (int a = 0; a < 256; a++) begin
            dmem[a] = {~a[7:0], a[7:0]};
        end
        for (int p = 0; p < N_PRESET; p++) begin
            dmem[PRESET_ADDR[p]] = PRESET_DATA[p];
        end
        fill_expected();
        // four cycles per program word and bubble plus slack
        limit = PROG_LEN;
        foreach (exp_bubbles[i]) begin
            limit += exp_bubbles[i];
        end
        limit = 4 * limit + 20;

        repeat (4) @(posedge gwe);
        #1 i_rst_n = 1'b1;
        @(negedge gwe);
        check_word("reset imem addr", START_PC, o_imem_addr);
        check_bit("reset dmem we", 1'b0, o_dmem_we);
        check_bit("reset wb we", 1'b0, o_wb_we);

        row     = 0;
        bubbles = 0;
        cycles  = 0;
        // one trace sample per falling edge
        while (row < exp_pc.size()) begin
            if (cycles >= limit) begin
                report_failure($sformatf("timeout after %0d cycles, %0d of %0d rows retired",
                                         cycles, row, exp_pc.size()));
            end
            if (o_wb_valid === 1'b1) begin
                check_count($sformatf("%s bubbles", exp_name[row]), exp_bubbles[row], bubbles);
                check_word($sformatf("%s pc", exp_name[row]), exp_pc[row], o_wb_pc);
                check_word($sformatf("%s insn", exp_name[row]), exp_insn[row], o_wb_insn);
                check_stall($sformatf("%s stall", exp_name[row]), STALL_NONE, o_wb_stall);
                check_bit($sformatf("%s we", exp_name[row]), exp_we[row], o_wb_we);
                // sel and data only mean something on a register write
                if (exp_we[row]) begin
                    check_sel($sformatf("%s sel", exp_name[row]), exp_sel[row], o_wb_sel);
                    check_word($sformatf("%s data", exp_name[row]), exp_data[row], o_wb_data);
                end
                row++;
                bubbles = 0;
            end else if (o_wb_valid === 1'b0) begin
                if (bubbles >= exp_bubbles[row]) begin
                    report_failure($sformatf("more bubbles than expected before %s",
                                             exp_name[row]));
                end
                check_stall($sformatf("bubble before %s", exp_name[row]), exp_code[row],
                            o_wb_stall);
                check_bit($sformatf("bubble we before %s", exp_name[row]), 1'b0, o_wb_we);
                bubbles++;
            end else begin
                report_failure("o_wb_valid is unknown during the run");
            end
            cycles++;
            @(negedge gwe);
        end

        // the store wrote the sum over the preset word
        check_word("stored word at 0x45", 16'h123C, dmem[8'h45]);
        $display("Test OK");
        $finish;
    end

endmodule
